// File: filelist.f
mac_tx_pkg.sv
pkt_rd_if.sv
show_ahead_fifo.sv
pkt_buffer.sv
mac_tx_fsm.sv
mac_tx_adapter.sv
mac_tx_adapter_assert.sv
tb_mac_tx_adapter.sv

// File: mac_tx_adapter.sv
// Top level of the transmit adapter from 134-bit packet words to the 8-bit MAC FIFO interface
module mac_tx_adapter #(
	parameter int WORD_DEPTH = mac_tx_pkg::DEF_WORD_DEPTH,
	parameter int FLAG_DEPTH = mac_tx_pkg::DEF_FLAG_DEPTH
) (
	input  logic         ff_tx_clk,
	input  logic         reset,

	// Upstream packet words and flags
	input  logic         data_in_wrreq,
	input  logic [133:0] data_in,
	input  logic         data_in_valid_wrreq,
	input  logic         data_in_valid,
	output logic         data_in_almostfull,

	// MAC transmit FIFO
	input  logic         ff_tx_rdy,
	output logic [7:0]   ff_tx_data,
	output logic         ff_tx_sop,
	output logic         ff_tx_eop,
	output logic         ff_tx_wren,
	output logic         ff_tx_crc_fwd,

	// Accepted packet counter strobe
	output logic         pkt_send_add
);

	// Buffer to FSM read bundle
	pkt_rd_if rd_bus ();

	// ============================================================
	// Packet buffer
	// ============================================================
	pkt_buffer #(
		.WORD_DEPTH (WORD_DEPTH),
		.FLAG_DEPTH (FLAG_DEPTH)
	) i_buffer (
		.ff_tx_clk           (ff_tx_clk),
		.reset               (reset),
		.data_in_wrreq       (data_in_wrreq),
		.data_in             (data_in),
		.data_in_valid_wrreq (data_in_valid_wrreq),
		.data_in_valid       (data_in_valid),
		.data_in_almostfull  (data_in_almostfull),
		.rd                  (rd_bus.buffer)
	);

	// ============================================================
	// Transmit FSM
	// ============================================================
	mac_tx_fsm i_fsm (
		.ff_tx_clk     (ff_tx_clk),
		.reset         (reset),
		.ff_tx_rdy     (ff_tx_rdy),
		.rd            (rd_bus.reader),
		.ff_tx_data    (ff_tx_data),
		.ff_tx_sop     (ff_tx_sop),
		.ff_tx_eop     (ff_tx_eop),
		.ff_tx_wren    (ff_tx_wren),
		.ff_tx_crc_fwd (ff_tx_crc_fwd),
		.pkt_send_add  (pkt_send_add)
	);

endmodule

// File: mac_tx_adapter_assert.sv
// Checker that bind attaches to the MAC transmit adapter to watch framing, stalls and almost-full
module mac_tx_adapter_assert (
	input logic       ff_tx_clk,
	input logic       reset,
	input logic       data_in_wrreq,
	input logic       data_in_almostfull,
	input logic       ff_tx_rdy,
	input logic [7:0] ff_tx_data,
	input logic       ff_tx_sop,
	input logic       ff_tx_eop,
	input logic       ff_tx_wren,
	input logic       ff_tx_crc_fwd,
	input logic       pkt_send_add
);
	timeunit 1ns;
	timeprecision 1ps;

	// Half of the default word FIFO depth
	localparam int AF_LEVEL = 128;

	int         fail_count = 0;
	logic       in_pkt;
	logic [7:0] last_byte;
	logic [7:0] first_byte;
	int         beat_count;
	int         adds_pending;
	int         low_writes;
	logic [7:0] first_now;
	int         beats_now;

	// Packet state including the beat now on the bus
	assign first_now = ff_tx_sop ? ff_tx_data : first_byte;
	assign beats_now = ff_tx_sop ? 1 : beat_count + 1;

	always_ff @(posedge ff_tx_clk or negedge reset) begin
		if (!reset) begin
			in_pkt       <= 1'b0;
			last_byte    <= '0;
			first_byte   <= '0;
			beat_count   <= 0;
			adds_pending <= 0;
			low_writes   <= 0;
		end else begin
			if (ff_tx_wren) begin
				last_byte  <= ff_tx_data;
				first_byte <= first_now;
				beat_count <= beats_now;
				in_pkt     <= !ff_tx_eop;
			end
			adds_pending <= adds_pending + int'(pkt_send_add)
				- int'(ff_tx_wren && ff_tx_sop);
			// Words written since the MAC last took bytes
			if (ff_tx_rdy) begin
				low_writes <= 0;
			end else if (data_in_wrreq) begin
				low_writes <= low_writes + 1;
			end
		end
	end

	// ============================================================
	// Byte stream and framing
	// ============================================================
	a_step: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		(ff_tx_wren && !ff_tx_sop) |-> (in_pkt && ff_tx_data == 8'(last_byte + 8'd1)))
		else begin
			$error("[FAIL] %0t byte %0h after %0h", $time, $sampled(ff_tx_data), last_byte);
			fail_count++;
		end

	// Bad packets start at 128 or above and must never open here
	a_sop: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		(ff_tx_wren && ff_tx_sop) |-> (!in_pkt && ff_tx_data < 8'd128 && adds_pending == 1))
		else begin
			$error("[FAIL] %0t sop byte %0h, %0d adds pending", $time, $sampled(ff_tx_data),
				adds_pending);
			fail_count++;
		end

	a_len: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		(ff_tx_wren && ff_tx_eop) |-> (beats_now == int'(first_now)))
		else begin
			$error("[FAIL] %0t packet of %0d bytes, first byte %0d", $time, beats_now,
				first_now);
			fail_count++;
		end

	// An add may share its cycle with the sop beat of the packet before
	a_add: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		pkt_send_add |-> (adds_pending == int'(ff_tx_wren && ff_tx_sop)))
		else begin
			$error("[FAIL] %0t second pkt_send_add before sop", $time);
			fail_count++;
		end

	// ============================================================
	// Stalls, CRC level, reset and almost-full
	// ============================================================
	a_stall: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		!ff_tx_rdy |=> !ff_tx_wren)
		else begin
			$error("[FAIL] %0t wren high after a cycle without ready", $time);
			fail_count++;
		end

	a_crc: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		ff_tx_crc_fwd == !ff_tx_eop)
		else begin
			$error("[FAIL] %0t crc_fwd %0b with eop %0b", $time, ff_tx_crc_fwd, ff_tx_eop);
			fail_count++;
		end

	a_reset: assert property (@(posedge ff_tx_clk)
		!reset |-> (!ff_tx_wren && !ff_tx_sop && !ff_tx_eop && !pkt_send_add
			&& ff_tx_crc_fwd && !data_in_almostfull))
		else begin
			$error("[FAIL] %0t outputs not idle during reset", $time);
			fail_count++;
		end

	a_afull: assert property (@(posedge ff_tx_clk) disable iff (!reset)
		(!ff_tx_rdy && low_writes >= AF_LEVEL) |=> data_in_almostfull)
		else begin
			$error("[FAIL] %0t almost-full low after %0d writes", $time, low_writes);
			fail_count++;
		end

endmodule

bind mac_tx_adapter mac_tx_adapter_assert i_checks (.*);

// File: mac_tx_fsm.sv
// Transmit FSM that sends valid packets byte by byte to the MAC FIFO and drops invalid ones
module mac_tx_fsm (
	input  logic       ff_tx_clk,
	input  logic       reset,
	input  logic       ff_tx_rdy,
	pkt_rd_if.reader   rd,
	output logic [7:0] ff_tx_data,
	output logic       ff_tx_sop,
	output logic       ff_tx_eop,
	output logic       ff_tx_wren,
	output logic       ff_tx_crc_fwd,
	output logic       pkt_send_add
);

	typedef enum logic [1:0] {
		st_idle,
		st_transmit,
		st_discard
	} state_t;

	state_t                state;
	mac_tx_pkg::pkt_word_t cur_word;
	mac_tx_pkg::byte_idx_t byte_idx;
	mac_tx_pkg::byte_idx_t last_idx;
	logic [7:0]            cur_byte;
	logic                  cur_head;
	logic                  cur_tail;
	logic                  q_tail;
	logic                  accept;
	logic                  word_end;
	logic                  pkt_end;

	// ============================================================
	// Word decode
	// ============================================================
	assign cur_head = |(cur_word.pos & mac_tx_pkg::pos_head);
	assign cur_tail = |(cur_word.pos & mac_tx_pkg::pos_tail);
	assign q_tail   = |(rd.word_q.pos & mac_tx_pkg::pos_tail);

	// MSB first, byte 0 is payload[127:120]
	assign cur_byte =
		cur_word.payload[8*(mac_tx_pkg::BYTES_PER_WORD - 1 - byte_idx) +: 8];

	// Last real byte of a tail word
	assign last_idx = mac_tx_pkg::byte_idx_t'(mac_tx_pkg::BYTES_PER_WORD - 1)
		- cur_word.empty_bytes;
	assign pkt_end  = cur_tail && (byte_idx == last_idx);
	assign word_end = (byte_idx == mac_tx_pkg::byte_idx_t'(mac_tx_pkg::BYTES_PER_WORD - 1));

	// Take a packet only when the MAC can accept bytes
	assign accept = (state == st_idle) && ff_tx_rdy && !rd.flag_empty;

	// ============================================================
	// Buffer reads
	// ============================================================
	// Head word popped on accept, next word at byte 15, one per cycle in discard
	assign rd.flag_rd = accept;
	assign rd.word_rd = accept
		|| ((state == st_transmit) && ff_tx_rdy && word_end && !pkt_end)
		|| (state == st_discard);

	// One count per accepted packet
	assign pkt_send_add = accept && rd.flag_q;

	// Current word follows every read, the discard path never looks at it
	always_ff @(posedge ff_tx_clk) begin
		if (rd.word_rd) begin
			cur_word <= rd.word_q;
		end
	end

	// ============================================================
	// State and MAC outputs
	// ============================================================
	always_ff @(posedge ff_tx_clk or negedge reset) begin
		if (!reset) begin
			state         <= st_idle;
			byte_idx      <= '0;
			ff_tx_data    <= '0;
			ff_tx_sop     <= 1'b0;
			ff_tx_eop     <= 1'b0;
			ff_tx_wren    <= 1'b0;
			ff_tx_crc_fwd <= 1'b1;
		end else begin
			case (state)
				st_idle: begin
					ff_tx_wren    <= 1'b0;
					ff_tx_sop     <= 1'b0;
					ff_tx_eop     <= 1'b0;
					ff_tx_crc_fwd <= 1'b1;
					byte_idx      <= '0;
					if (accept) begin
						if (rd.flag_q) begin
							state <= st_transmit;
						end else if (!q_tail) begin
							// Single-word bad packet is gone with the accept read
							state <= st_discard;
						end
					end
				end
				st_transmit: begin
					if (ff_tx_rdy) begin
						ff_tx_data <= cur_byte;
						ff_tx_wren <= 1'b1;
						ff_tx_sop  <= cur_head && (byte_idx == '0);
						if (pkt_end) begin
							ff_tx_eop     <= 1'b1;
							ff_tx_crc_fwd <= 1'b0;
							state         <= st_idle;
						end else begin
							// Wraps to 0 after byte 15 as the next word loads
							byte_idx <= byte_idx + 1'b1;
						end
					end else begin
						// MAC stalled, hold position
						ff_tx_wren <= 1'b0;
					end
				end
				st_discard: begin
					if (q_tail) begin
						state <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

// File: mac_tx_pkg.sv
// Shared word layout, position codes and buffer depths for the MAC transmit adapter
package mac_tx_pkg;

	// ============================================================
	// Word layout
	// ============================================================

	// Payload bytes per upstream word
	localparam int BYTES_PER_WORD = 16;

	// Position codes, one bit each for head and tail
	// A single-word packet carries both bits set
	localparam logic [1:0] pos_head = 2'b01;
	localparam logic [1:0] pos_tail = 2'b10;
	localparam logic [1:0] pos_mid  = 2'b00;

	// 134-bit upstream word, first byte on the wire sits in payload[127:120]
	typedef struct packed {
		logic [1:0]                      pos;
		// Unused trailing bytes, only meaningful in a tail word
		logic [3:0]                      empty_bytes;
		logic [BYTES_PER_WORD*8-1:0]     payload;
	} pkt_word_t;

	// Byte position within one word
	typedef logic [3:0] byte_idx_t;

	// ============================================================
	// Buffer depths
	// ============================================================

	// Word FIFO, almost-full is raised at half of this
	localparam int DEF_WORD_DEPTH = 256;

	// One valid/invalid flag per buffered packet
	localparam int DEF_FLAG_DEPTH = 64;

endpackage

// File: pkt_buffer.sv
// Packet word store and per-packet flag store in front of the transmit FSM
module pkt_buffer #(
	parameter int WORD_DEPTH = mac_tx_pkg::DEF_WORD_DEPTH,
	parameter int FLAG_DEPTH = mac_tx_pkg::DEF_FLAG_DEPTH
) (
	input  logic                  ff_tx_clk,
	input  logic                  reset,
	input  logic                  data_in_wrreq,
	input  mac_tx_pkg::pkt_word_t data_in,
	input  logic                  data_in_valid_wrreq,
	input  logic                  data_in_valid,
	output logic                  data_in_almostfull,
	pkt_rd_if.buffer              rd
);

	localparam int USED_W = $clog2(WORD_DEPTH + 1);
	localparam logic [USED_W-1:0] HALF_FULL = USED_W'(WORD_DEPTH / 2);

	logic [USED_W-1:0] word_used;

	// ============================================================
	// Word FIFO
	// ============================================================
	show_ahead_fifo #(
		.payload_t (mac_tx_pkg::pkt_word_t),
		.DEPTH     (WORD_DEPTH)
	) i_word_fifo (
		.ff_tx_clk (ff_tx_clk),
		.reset     (reset),
		.wr        (data_in_wrreq),
		.din       (data_in),
		.rd        (rd.word_rd),
		.q         (rd.word_q),
		.empty     (),
		.used      (word_used)
	);

	// ============================================================
	// Flag FIFO
	// ============================================================
	// Written after the tail word, so a flag means a whole packet is here
	show_ahead_fifo #(
		.payload_t (logic),
		.DEPTH     (FLAG_DEPTH)
	) i_flag_fifo (
		.ff_tx_clk (ff_tx_clk),
		.reset     (reset),
		.wr        (data_in_valid_wrreq),
		.din       (data_in_valid),
		.rd        (rd.flag_rd),
		.q         (rd.flag_q),
		.empty     (rd.flag_empty),
		.used      ()
	);

	// Upstream throttle at half depth
	always_ff @(posedge ff_tx_clk or negedge reset) begin
		if (!reset) begin
			data_in_almostfull <= 1'b0;
		end else begin
			data_in_almostfull <= (word_used >= HALF_FULL);
		end
	end

endmodule

// File: pkt_rd_if.sv
// Read side of the packet buffer as seen by the transmit FSM, one bundle for both FIFOs
interface pkt_rd_if;

	// Head of the word FIFO and its read strobe
	mac_tx_pkg::pkt_word_t word_q;
	logic                  word_rd;

	// Head of the flag FIFO, high for a packet worth sending
	logic                  flag_q;
	logic                  flag_rd;

	// No flag means no complete packet yet
	logic                  flag_empty;

	// FIFO side presents data and status
	modport buffer (
		output word_q,
		output flag_q,
		output flag_empty,
		input  word_rd,
		input  flag_rd
	);

	// FSM side pops entries
	modport reader (
		input  word_q,
		input  flag_q,
		input  flag_empty,
		output word_rd,
		output flag_rd
	);

endinterface

// File: show_ahead_fifo.sv
// Single-clock first-word-fall-through FIFO, instantiated for packet words and packet flags
module show_ahead_fifo #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 16
) (
	input  logic                         ff_tx_clk,
	input  logic                         reset,
	input  logic                         wr,
	input  payload_t                     din,
	input  logic                         rd,
	output payload_t                     q,
	output logic                         empty,
	output logic [$clog2(DEPTH+1)-1:0]   used
);

	localparam int AW     = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int USED_W = $clog2(DEPTH + 1);

	payload_t       mem [DEPTH];
	logic [AW-1:0]  wr_ptr;
	logic [AW-1:0]  rd_ptr;
	logic           full;
	logic           do_wr;
	logic           do_rd;

	// Circular pointer step, depth need not be a power of two
	function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
		logic [AW-1:0] nxt;
		if (ptr == AW'(DEPTH - 1)) begin
			nxt = '0;
		end else begin
			nxt = ptr + 1'b1;
		end
		return nxt;
	endfunction

	assign full  = (used == USED_W'(DEPTH));
	assign empty = (used == '0);

	// Overflow and underflow strobes are dropped
	assign do_wr = wr && !full;
	assign do_rd = rd && !empty;

	// Oldest entry shows without read latency
	assign q = mem[rd_ptr];

	always_ff @(posedge ff_tx_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= din;
		end
	end

	always_ff @(posedge ff_tx_clk or negedge reset) begin
		if (!reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			used   <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_rd) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			// Fill count, unchanged on simultaneous push and pop
			case ({do_wr, do_rd})
				2'b10:   used <= used + 1'b1;
				2'b01:   used <= used - 1'b1;
				default: used <= used;
			endcase
		end
	end

endmodule

// File: tb_mac_tx_adapter.sv
// Testbench for the MAC transmit adapter that drives random packets and stalls for bound checks
module tb_mac_tx_adapter;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_PKTS   = 60;
	localparam int NUM_STALLS = 30;
	localparam int AF_WORDS   = 130;

	logic         ff_tx_clk = 1'b0;
	logic         reset;
	logic         data_in_wrreq;
	logic [133:0] data_in;
	logic         data_in_valid_wrreq;
	logic         data_in_valid;
	logic         data_in_almostfull;
	logic         ff_tx_rdy;
	logic [7:0]   ff_tx_data;
	logic         ff_tx_sop;
	logic         ff_tx_eop;
	logic         ff_tx_wren;
	logic         ff_tx_crc_fwd;
	logic         pkt_send_add;

	logic [31:0]  rng_state = 32'd30;
	int           pkt_len [NUM_PKTS];
	logic         pkt_ok [NUM_PKTS];
	int           stall_gap [NUM_STALLS];
	int           stall_len [NUM_STALLS];
	int           valid_pkts = 0;
	int           watch_cycles = 0;
	int           eops_seen = 0;

	mac_tx_adapter i_dut (.*);

	always #(CLK_PERIOD / 2) ff_tx_clk = ~ff_tx_clk;

	// Count of sent packets to see when traffic has drained
	always @(posedge ff_tx_clk) begin
		if (reset && ff_tx_wren && ff_tx_eop) begin
			eops_seen <= eops_seen + 1;
		end
	end

	// ============================================================
	// Random numbers and stimulus data
	// ============================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_between(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return lo + int'(rng_state % 32'(hi - lo + 1));
	endfunction

	// Byte k of a packet is base plus k with the first byte in the top bits
	function automatic logic [133:0] build_word(input int len, input int base, input int w);
		mac_tx_pkg::pkt_word_t word;
		int nwords;
		int k;
		nwords = (len + 15) / 16;
		word.pos = mac_tx_pkg::pos_mid;
		word.empty_bytes = 4'd0;
		if (w == 0) begin
			word.pos = word.pos | mac_tx_pkg::pos_head;
		end
		if (w == nwords - 1) begin
			word.pos = word.pos | mac_tx_pkg::pos_tail;
			word.empty_bytes = 4'(nwords * 16 - len);
		end
		for (k = 0; k < 16; k++) begin
			word.payload[8 * (15 - k) +: 8] = 8'(base + 16 * w + k);
		end
		return word;
	endfunction

	function automatic void build_schedule();
		int i;
		int total_bytes;
		int stall_total;
		total_bytes = 0;
		stall_total = 0;
		for (i = 0; i < NUM_PKTS; i++) begin
			pkt_len[i] = rand_between(1, 100);
			// About one in four is bad and the last one always goes out
			pkt_ok[i] = (i == NUM_PKTS - 1) || (rand_between(0, 3) != 0);
			valid_pkts += pkt_ok[i] ? 1 : 0;
			total_bytes += pkt_len[i];
		end
		for (i = 0; i < NUM_STALLS; i++) begin
			stall_gap[i] = rand_between(5, 20);
			stall_len[i] = rand_between(1, 8);
			stall_total += stall_len[i];
		end
		watch_cycles = 40 * (NUM_PKTS + 4) + total_bytes + stall_total + 3 * AF_WORDS;
	endfunction

	// ============================================================
	// Drivers
	// ============================================================
	task automatic send_packet(input int len, input int base, input logic ok);
		int nwords;
		int w;
		nwords = (len + 15) / 16;
		for (w = 0; w < nwords; w++) begin
			@(posedge ff_tx_clk);
			data_in_wrreq <= 1'b1;
			data_in       <= build_word(len, base, w);
		end
		// Flag follows the tail word
		@(posedge ff_tx_clk);
		data_in_wrreq       <= 1'b0;
		data_in_valid_wrreq <= 1'b1;
		data_in_valid       <= ok;
		@(posedge ff_tx_clk);
		data_in_valid_wrreq <= 1'b0;
	endtask

	task automatic write_random_packets();
		int i;
		for (i = 0; i < NUM_PKTS; i++) begin
			while (data_in_almostfull) begin
				@(posedge ff_tx_clk);
			end
			send_packet(pkt_len[i], pkt_ok[i] ? pkt_len[i] : pkt_len[i] + 128, pkt_ok[i]);
		end
	endtask

	task automatic drive_stalls();
		int i;
		for (i = 0; i < NUM_STALLS; i++) begin
			repeat (stall_gap[i]) @(posedge ff_tx_clk);
			ff_tx_rdy <= 1'b0;
			repeat (stall_len[i]) @(posedge ff_tx_clk);
			ff_tx_rdy <= 1'b1;
		end
	endtask

	task automatic wait_for_eops(input int target);
		while (eops_seen < target) begin
			@(posedge ff_tx_clk);
		end
	endtask

	initial begin : watchdog
		wait (watch_cycles > 0);
		repeat (watch_cycles) @(posedge ff_tx_clk);
		$display("Timeout: only %0d packets sent after %0d cycles", eops_seen, watch_cycles);
		$display("Done: errors found");
		$finish;
	end

	initial begin
		reset               = 1'b1;
		data_in_wrreq       = 1'b0;
		data_in             = '0;
		data_in_valid_wrreq = 1'b0;
		data_in_valid       = 1'b0;
		ff_tx_rdy           = 1'b0;
		build_schedule();
		#1;
		reset = 1'b0;
		repeat (3) @(posedge ff_tx_clk);
		reset     <= 1'b1;
		ff_tx_rdy <= 1'b1;

		fork
			write_random_packets();
			drive_stalls();
		join
		wait_for_eops(valid_pkts);

		// MAC held off while a long bad packet fills the word FIFO past half
		@(posedge ff_tx_clk);
		ff_tx_rdy <= 1'b0;
		send_packet(AF_WORDS * 16, 200, 1'b0);
		repeat (4) @(posedge ff_tx_clk);
		ff_tx_rdy <= 1'b1;
		// Queued behind the long discard so they leave back to back
		send_packet(3, 131, 1'b0);
		send_packet(1, 1, 1'b1);
		send_packet(5, 5, 1'b1);
		wait_for_eops(valid_pkts + 2);
		repeat (2) @(posedge ff_tx_clk);

		$display("Summary: %0d assertion failures, %0d packets sent",
			i_dut.i_checks.fail_count, eops_seen);
		if (i_dut.i_checks.fail_count == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule
